// File: source/blockproc_pkg.sv
// block geometry constants, pixel and statistics types, sequencer state encoding
`default_nettype none

package blockproc_pkg;

	// an 8x8 block is 64 pixels
	localparam int PIX_PER_BLK = 64;
	// pixel index width within a block
	localparam int PIX_BITS = 6;

	// one unsigned 8-bit pixel
	typedef logic [7:0] pixel_t;

	// sum of 64 pixels, max 64*255 = 16320
	typedef logic [13:0] blk_sum_t;

	// one-hot sequencer state
	typedef enum logic [15:0] {
		IDLE         = 16'h0001,
		GEN_BLK_ADDR = 16'h0002,
		WAIT0        = 16'h0004,
		CNT1         = 16'h0008,
		WAIT1        = 16'h0010,
		CNT2         = 16'h0020,
		WAIT2        = 16'h0040,
		CNT3         = 16'h0080,
		WAIT3        = 16'h0100,
		CNT4         = 16'h0200,
		WAIT4        = 16'h0400,
		CNT5         = 16'h0800,
		WAIT5        = 16'h1000,
		CNT6         = 16'h2000,
		DLY          = 16'h4000,
		NEXT_BLK     = 16'h8000
	} seq_state_t;

	// per-block statistics record, as handed to the quantiser stage
	typedef struct packed {
		blk_sum_t sum;
		pixel_t   mean;
		pixel_t   min;
		pixel_t   max;
	} block_stats_t;

endpackage

`default_nettype wire

// File: source/stage_ctrl_if.sv
// stage strobe interface between block sequencer and statistics datapath
`timescale 1ns/1ps
`default_nettype none

interface stage_ctrl_if #(
	parameter int BLK_BITS = 12
);

	// copy the sipo contents into the datapath
	logic latch_en;
	// row sums, block sum, min/max, mean
	logic dp1_en;
	logic dp2_en;
	logic dp3_en;
	logic dp4_en;
	// result write
	logic wr;
	// block number, stable for the whole block
	logic [BLK_BITS-1:0] blk_idx;

	modport sequencer (
		output latch_en, dp1_en, dp2_en, dp3_en, dp4_en, wr,
		output blk_idx
	);

	modport stats (
		input latch_en, dp1_en, dp2_en, dp3_en, dp4_en, wr,
		input blk_idx
	);

endinterface

`default_nettype wire

// File: source/block_sequencer.sv
// block sequencer: one-hot frame FSM, pixel and block counters, read address, stage strobes
`timescale 1ns/1ps
`default_nettype none

module block_sequencer
	import blockproc_pkg::*;
#(
	parameter int BLK_BITS = 12
) (
	input  logic                          clk,
	input  logic                          reset_,
	input  logic                          get_data,
	output logic                          rd,
	output logic [BLK_BITS+PIX_BITS-1:0]  rd_addr,
	output logic                          frame_done,
	stage_ctrl_if.sequencer               ctrl
);

	seq_state_t state;
	seq_state_t next_state;

	// pixel number inside the current block
	logic [PIX_BITS-1:0] pix_cnt;
	// block number inside the frame
	logic [BLK_BITS-1:0] blk_cnt;

	// last pixel of the address burst
	logic last_pix;
	// last block of the frame, counter all ones
	logic last_blk;

	assign last_pix = &pix_cnt;
	assign last_blk = &blk_cnt;

	// state register
	always_ff @(posedge clk) begin
		if (!reset_) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// pixel counter runs only during the burst
	// and wraps to zero on the last pixel
	always_ff @(posedge clk) begin
		if (!reset_) begin
			pix_cnt <= '0;
		end else if (state == GEN_BLK_ADDR) begin
			pix_cnt <= pix_cnt + 1'b1;
		end else begin
			pix_cnt <= '0;
		end
	end

	// block counter steps once per block in NEXT_BLK
	// wrap after the last block leaves it at zero for the next frame
	always_ff @(posedge clk) begin
		if (!reset_) begin
			blk_cnt <= '0;
		end else if (state == NEXT_BLK) begin
			blk_cnt <= blk_cnt + 1'b1;
		end
	end

	// next state
	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				// get_data only matters here
				if (get_data) begin
					next_state = GEN_BLK_ADDR;
				end
			end
			GEN_BLK_ADDR: begin
				// 64 reads then the stage chain
				if (last_pix) begin
					next_state = WAIT0;
				end
			end
			// one idle cycle between each stage strobe
			WAIT0: next_state = CNT1;
			CNT1:  next_state = WAIT1;
			WAIT1: next_state = CNT2;
			CNT2:  next_state = WAIT2;
			WAIT2: next_state = CNT3;
			CNT3:  next_state = WAIT3;
			WAIT3: next_state = CNT4;
			CNT4:  next_state = WAIT4;
			WAIT4: next_state = CNT5;
			CNT5:  next_state = WAIT5;
			WAIT5: next_state = CNT6;
			CNT6:  next_state = DLY;
			DLY:   next_state = NEXT_BLK;
			NEXT_BLK: begin
				if (last_blk) begin
					next_state = IDLE;
				end else begin
					next_state = GEN_BLK_ADDR;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	// read strobe, also the sipo enable
	assign rd = (state == GEN_BLK_ADDR);

	// block number above pixel number
	assign rd_addr = {blk_cnt, pix_cnt};

	// one cycle at the end of the last block
	assign frame_done = (state == NEXT_BLK) && last_blk;

	// stage strobes straight from the state decode
	assign ctrl.latch_en = (state == CNT1);
	assign ctrl.dp1_en   = (state == CNT2);
	assign ctrl.dp2_en   = (state == CNT3);
	assign ctrl.dp3_en   = (state == CNT4);
	assign ctrl.dp4_en   = (state == CNT5);
	assign ctrl.wr       = (state == CNT6);

	// block index held until NEXT_BLK steps the counter
	assign ctrl.blk_idx = blk_cnt;

endmodule

`default_nettype wire

// File: source/pixel_sipo.sv
// 64-pixel serial-in parallel-out buffer fed by the memory read data
`timescale 1ns/1ps
`default_nettype none

module pixel_sipo
	import blockproc_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset_,
	input  logic                       rd,
	input  pixel_t                     data,
	output pixel_t [PIX_PER_BLK-1:0]   block
);

	// rd delayed to line up with the synchronous memory output
	logic shift_en;

	// shift register, newest byte enters at the top
	pixel_t [PIX_PER_BLK-1:0] shreg;

	always_ff @(posedge clk) begin
		if (!reset_) begin
			shift_en <= 1'b0;
		end else begin
			shift_en <= rd;
		end
	end

	// each shift moves everything down by one pixel
	// after 64 shifts pixel 0 is at index 0 and index equals pixel number
	always_ff @(posedge clk) begin
		if (shift_en) begin
			shreg <= {data, shreg[PIX_PER_BLK-1:1]};
		end
	end

	// parallel view of the whole block
	// only complete between the last shift and the next block's first byte
	assign block = shreg;

endmodule

`default_nettype wire

// File: source/block_stats.sv
// block statistics datapath: block latch, row sums, block sum, min/max, mean, result write
`timescale 1ns/1ps
`default_nettype none

module block_stats
	import blockproc_pkg::*;
#(
	parameter int BLK_BITS = 12
) (
	input  logic                       clk,
	input  logic                       reset_,
	stage_ctrl_if.stats                ctrl,
	input  pixel_t [PIX_PER_BLK-1:0]   block,
	output logic                       res_wr,
	output logic [BLK_BITS-1:0]        res_blk,
	output block_stats_t               res_stats
);

	// 8 rows of 8 pixels
	localparam int ROWS = 8;
	localparam int ROW_LEN = PIX_PER_BLK / ROWS;
	// 8 pixels of 255 need 11 bits
	localparam int ROW_BITS = $bits(pixel_t) + $clog2(ROW_LEN);

	// private copy of the block, frees the sipo for the next burst
	pixel_t [PIX_PER_BLK-1:0] blk_q;
	logic [BLK_BITS-1:0] idx_q;

	// stage registers
	logic [ROWS-1:0][ROW_BITS-1:0] row_sum;
	blk_sum_t blk_sum;
	pixel_t min_q;
	pixel_t max_q;
	pixel_t mean_q;

	// stage inputs
	logic [ROWS-1:0][ROW_BITS-1:0] row_sum_d;
	blk_sum_t blk_sum_d;
	pixel_t min_d;
	pixel_t max_d;

	// dp1: row sums over the latched block
	always_comb begin
		for (int r = 0; r < ROWS; r++) begin
			row_sum_d[r] = '0;
			for (int c = 0; c < ROW_LEN; c++) begin
				row_sum_d[r] = row_sum_d[r] + ROW_BITS'(blk_q[r*ROW_LEN + c]);
			end
		end
	end

	// dp2: add the row sums
	always_comb begin
		blk_sum_d = '0;
		for (int r = 0; r < ROWS; r++) begin
			blk_sum_d = blk_sum_d + blk_sum_t'(row_sum[r]);
		end
	end

	// dp3: min and max scan, starting from pixel 0
	always_comb begin
		min_d = blk_q[0];
		max_d = blk_q[0];
		for (int i = 1; i < PIX_PER_BLK; i++) begin
			if (blk_q[i] < min_d) begin
				min_d = blk_q[i];
			end
			if (blk_q[i] > max_d) begin
				max_d = blk_q[i];
			end
		end
	end

	// payload registers, one enable per stage
	always_ff @(posedge clk) begin
		if (ctrl.latch_en) begin
			blk_q <= block;
			idx_q <= ctrl.blk_idx;
		end
		if (ctrl.dp1_en) begin
			row_sum <= row_sum_d;
		end
		if (ctrl.dp2_en) begin
			blk_sum <= blk_sum_d;
		end
		if (ctrl.dp3_en) begin
			min_q <= min_d;
			max_q <= max_d;
		end
		// dp4: mean is sum / 64, truncated
		if (ctrl.dp4_en) begin
			mean_q <= pixel_t'(blk_sum >> PIX_BITS);
		end
		// result record, held until the next block's write
		if (ctrl.wr) begin
			res_blk        <= idx_q;
			res_stats.sum  <= blk_sum;
			res_stats.mean <= mean_q;
			res_stats.min  <= min_q;
			res_stats.max  <= max_q;
		end
	end

	// write pulse, one cycle after wr together with the record
	always_ff @(posedge clk) begin
		if (!reset_) begin
			res_wr <= 1'b0;
		end else begin
			res_wr <= ctrl.wr;
		end
	end

endmodule

`default_nettype wire

// File: source/block_engine_top.sv
// frame block engine top: sequencer, pixel sipo, statistics datapath and their wiring
`timescale 1ns/1ps
`default_nettype none

module block_engine_top
	import blockproc_pkg::*;
#(
	// 12 bits gives 4096 blocks and an 18-bit read address
	parameter int BLK_BITS = 12
) (
	input  logic                          clk,
	input  logic                          reset_,
	input  logic                          get_data,
	input  pixel_t                        data,
	output logic                          rd,
	output logic [BLK_BITS+PIX_BITS-1:0]  rd_addr,
	output logic                          frame_done,
	output logic                          res_wr,
	output logic [BLK_BITS-1:0]           res_blk,
	output blk_sum_t                      res_sum,
	output pixel_t                        res_mean,
	output pixel_t                        res_min,
	output pixel_t                        res_max
);

	// stage strobes and block index
	stage_ctrl_if #(.BLK_BITS(BLK_BITS)) ctrl_if ();

	// sipo contents into the datapath
	pixel_t [PIX_PER_BLK-1:0] sipo_block;
	block_stats_t stats;

	block_sequencer #(.BLK_BITS(BLK_BITS)) u_seq (
		.clk        (clk),
		.reset_     (reset_),
		.get_data   (get_data),
		.rd         (rd),
		.rd_addr    (rd_addr),
		.frame_done (frame_done),
		.ctrl       (ctrl_if.sequencer)
	);

	// rd doubles as the sipo shift request
	pixel_sipo u_sipo (
		.clk    (clk),
		.reset_ (reset_),
		.rd     (rd),
		.data   (data),
		.block  (sipo_block)
	);

	block_stats #(.BLK_BITS(BLK_BITS)) u_stats (
		.clk       (clk),
		.reset_    (reset_),
		.ctrl      (ctrl_if.stats),
		.block     (sipo_block),
		.res_wr    (res_wr),
		.res_blk   (res_blk),
		.res_stats (stats)
	);

	// record fields out to separate ports
	assign res_sum  = stats.sum;
	assign res_mean = stats.mean;
	assign res_min  = stats.min;
	assign res_max  = stats.max;

endmodule

`default_nettype wire

// File: tests/block_engine_checker.sv
// sequencer assertions: one-hot state, exclusive strobes, address steps, frame done placement
`timescale 1ns/1ps
`default_nettype none

module block_engine_checker
	import blockproc_pkg::*;
(
	input logic                clk,
	input logic                reset_,
	input seq_state_t          state,
	input logic                rd,
	input logic [PIX_BITS-1:0] pix,
	input logic [5:0]          strobes,
	input logic                frame_done
);

	// failures per assertion, summed for the testbench summary
	int onehot_fails = 0;
	int excl_fails = 0;
	int step_fails = 0;
	int done_fails = 0;
	int fail_count;

	assign fail_count = onehot_fails + excl_fails + step_fails + done_fails;

	// exactly one state bit set
	state_onehot: assert property (@(posedge clk) disable iff (!reset_) $onehot(state))
		else begin
			$error("sequencer state %h is not one-hot", state);
			onehot_fails++;
		end

	// read burst and stage strobes never overlap
	strobe_excl: assert property (@(posedge clk) disable iff (!reset_) $onehot0({rd, strobes}))
		else begin
			$error("rd and stage strobes overlap: %b", {rd, strobes});
			excl_fails++;
		end

	// pixel part of the address climbs by one inside a burst
	addr_step: assert property (@(posedge clk) disable iff (!reset_)
		rd ##1 rd |-> pix == PIX_BITS'($past(pix) + 1))
		else begin
			$error("pixel address jumped to %h", pix);
			step_fails++;
		end

	// frame done only at the end of the last block
	done_place: assert property (@(posedge clk) disable iff (!reset_)
		frame_done |-> state == NEXT_BLK)
		else begin
			$error("frame_done outside NEXT_BLK, state %h", state);
			done_fails++;
		end

endmodule

bind block_sequencer block_engine_checker u_checker (
	.clk        (clk),
	.reset_     (reset_),
	.state      (state),
	.rd         (rd),
	.pix        (rd_addr[PIX_BITS-1:0]),
	.strobes    ({ctrl.latch_en, ctrl.dp1_en, ctrl.dp2_en,
		ctrl.dp3_en, ctrl.dp4_en, ctrl.wr}),
	.frame_done (frame_done)
);

`default_nettype wire

// File: tests/block_engine_tb.sv
// block engine testbench: memory model, reference statistics, compare tasks, directed tests
`timescale 1ns/1ps
`default_nettype none

module block_engine_tb
	import blockproc_pkg::*;
;

	localparam int BLK_BITS = 4;
	localparam int ADDR_BITS = BLK_BITS + PIX_BITS;
	localparam int NUM_BLK = 1 << BLK_BITS;
	localparam int MEM_WORDS = NUM_BLK * PIX_PER_BLK;
	// cycles from one burst start to the next
	localparam int BLK_PERIOD = 78;
	localparam int CLK_PERIOD = 10;
	// three frames plus reset, idle windows and margin
	localparam int WATCHDOG_CYCLES = 3 * NUM_BLK * BLK_PERIOD + 1000;

	logic clk;
	logic reset_;
	logic get_data;
	pixel_t data;
	logic rd;
	logic [ADDR_BITS-1:0] rd_addr;
	logic frame_done;
	logic res_wr;
	logic [BLK_BITS-1:0] res_blk;
	blk_sum_t res_sum;
	pixel_t res_mean;
	pixel_t res_min;
	pixel_t res_max;

	pixel_t mem [MEM_WORDS];
	int value_errs = 0;
	int proto_errs = 0;
	integer seed;

	block_engine_top #(.BLK_BITS(BLK_BITS)) uut (
		.clk(clk), .reset_(reset_), .get_data(get_data), .data(data),
		.rd(rd), .rd_addr(rd_addr), .frame_done(frame_done),
		.res_wr(res_wr), .res_blk(res_blk), .res_sum(res_sum),
		.res_mean(res_mean), .res_min(res_min), .res_max(res_max)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// synchronous RAM, data one cycle after rd
	always @(posedge clk) begin
		if (rd) begin
			data <= mem[rd_addr];
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// statistics of one block straight from the memory array
	function automatic block_stats_t ref_stats(input int b);
		block_stats_t s;
		int sum;
		pixel_t lo;
		pixel_t hi;
		sum = 0;
		lo = 8'hff;
		hi = 8'h00;
		for (int i = 0; i < PIX_PER_BLK; i++) begin
			sum += mem[b * PIX_PER_BLK + i];
			lo = (mem[b * PIX_PER_BLK + i] < lo) ? mem[b * PIX_PER_BLK + i] : lo;
			hi = (mem[b * PIX_PER_BLK + i] > hi) ? mem[b * PIX_PER_BLK + i] : hi;
		end
		s.sum = blk_sum_t'(sum);
		s.mean = pixel_t'(sum / PIX_PER_BLK);
		s.min = lo;
		s.max = hi;
		return s;
	endfunction

	task automatic check_stats(input block_stats_t got, input block_stats_t exp, input int b);
		if (got !== exp) begin
			value_errs++;
			$display("Error: res_stats block %0d got sum=%h mean=%h min=%h max=%h", b,
				got.sum, got.mean, got.min, got.max);
			$display("       expected sum=%h mean=%h min=%h max=%h",
				exp.sum, exp.mean, exp.min, exp.max);
		end
	endtask

	task automatic check_blk(input logic [BLK_BITS-1:0] got, input logic [BLK_BITS-1:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("Error: res_blk got %h expected %h", got, exp);
		end
	endtask

	task automatic check_addr(input logic [ADDR_BITS-1:0] got,
		input logic [ADDR_BITS-1:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("Error: rd_addr got %h expected %h", got, exp);
		end
	endtask

	// one-cycle start request, sampled at the second edge
	task automatic pulse_get_data();
		@(posedge clk);
		get_data <= 1'b1;
		@(posedge clk);
		get_data <= 1'b0;
	endtask

	task automatic expect_quiet(input int cycles, input string phase);
		repeat (cycles) begin
			@(negedge clk);
			if (rd || res_wr || frame_done) begin
				proto_errs++;
				$display("unexpected activity during %s: rd=%0b res_wr=%0b frame_done=%0b",
					phase, rd, res_wr, frame_done);
			end
		end
	endtask

	// one whole frame: addresses, burst spacing, records in order, single frame done
	task automatic run_frame(input bit poke_mid);
		int n_rd;
		int n_wr;
		int cyc;
		int burst_start;
		bit done;
		logic [ADDR_BITS-1:0] exp_addr;
		n_rd = 0;
		n_wr = 0;
		cyc = 0;
		burst_start = 0;
		done = 1'b0;
		pulse_get_data();
		while (!done) begin
			@(negedge clk);
			cyc++;
			// frame done must follow the last write, never share its cycle
			if (frame_done) begin
				done = 1'b1;
				if (n_wr != NUM_BLK || n_rd != MEM_WORDS) begin
					proto_errs++;
					$display("frame done came after %0d writes and %0d reads", n_wr, n_rd);
				end
			end
			if (rd) begin
				exp_addr = {BLK_BITS'(n_rd / PIX_PER_BLK), PIX_BITS'(n_rd % PIX_PER_BLK)};
				check_addr(rd_addr, exp_addr);
				if (n_rd % PIX_PER_BLK == 0) begin
					if (n_rd > 0 && cyc - burst_start != BLK_PERIOD) begin
						proto_errs++;
						$display("burst %0d started %0d cycles after the previous one",
							n_rd / PIX_PER_BLK, cyc - burst_start);
					end
					burst_start = cyc;
				end
				n_rd++;
			end
			if (res_wr) begin
				if (n_wr >= NUM_BLK) begin
					proto_errs++;
					$display("more result writes than blocks in the frame");
				end else begin
					check_blk(res_blk, BLK_BITS'(n_wr));
					check_stats({res_sum, res_mean, res_min, res_max},
						ref_stats(n_wr), n_wr);
				end
				n_wr++;
				// a start request in mid-frame must be ignored
				if (poke_mid && n_wr == 6) begin
					fork
						pulse_get_data();
					join_none
				end
			end
		end
		expect_quiet(100, "the gap after frame done");
	endtask

	task automatic test_idle_after_reset();
		expect_quiet(100, "idle after reset");
	endtask

	task automatic test_random_frame();
		seed = 156;
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem[a] = pixel_t'($random(seed));
		end
		run_frame(1'b1);
	endtask

	// zero, full scale, ramp and alternating-column blocks, then a second frame
	task automatic test_pattern_frames();
		for (int a = 0; a < MEM_WORDS; a++) begin
			case (a / PIX_PER_BLK)
				0: mem[a] = 8'h00;
				1: mem[a] = 8'hff;
				2: mem[a] = pixel_t'((a % PIX_PER_BLK) * 4 + 1);
				3: mem[a] = (a % 2 == 1) ? 8'hff : 8'h00;
				default: mem[a] = pixel_t'(a * 37 + (a >> 6));
			endcase
		end
		run_frame(1'b0);
		run_frame(1'b0);
	endtask

	initial begin
		reset_ = 1'b0;
		get_data = 1'b0;
		data = '0;
		repeat (16) @(posedge clk);
		reset_ <= 1'b1;
		test_idle_after_reset();
		test_random_frame();
		test_pattern_frames();
		$display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
			value_errs, proto_errs, uut.u_seq.u_checker.fail_count);
		if (value_errs == 0 && proto_errs == 0 && uut.u_seq.u_checker.fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
source/blockproc_pkg.sv
source/stage_ctrl_if.sv
source/block_sequencer.sv
source/pixel_sipo.sv
source/block_stats.sv
source/block_engine_top.sv
tests/block_engine_checker.sv
tests/block_engine_tb.sv

// File: Makefile
# Verilator lint and simulation of the frame block engine

TOP := block_engine_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --sv --timing --assert -f project.f --top-module $(TOP)

# warnings are still printed, they only stop being fatal for the build
sim:
	verilator --binary --sv --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
